/* Makefile */
TOP := wb_ram_bank_tb

.PHONY: all compile run clean

all: run

# builds obj_dir/Vwb_ram_bank_tb from the file list.
compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  --top-module $(TOP) -f wb_ram_bank.f

# the run fails unless the pass line appears in the output.
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* design/sram_sp_be.sv */
// Behavioral model with no reset and read-before-write, so a write cycle returns the old word.
`timescale 1ns/1ps

module sram_sp_be #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 256
) (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic [WIDTH/8-1:0]       we_i,
  input  logic [$clog2(DEPTH)-1:0] adr_i,
  input  logic [WIDTH-1:0]         dat_i,
  output logic [WIDTH-1:0]         dat_o
);

  // storage array, one entry per word.
  // the contents come up undefined and are never cleared.
  logic [WIDTH-1:0] mem [DEPTH];

  // the macro is strictly single ported.
  // one address serves the read and the write of the same cycle.
  // the read register only loads when the macro is enabled, so the
  // output holds the last word read while the bank is idle.
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      // the old contents are sampled before any lane is updated.
      // nonblocking assignment gives the read-before-write order.
      dat_o <= mem[adr_i];
      // each byte lane has its own write enable.
      // lanes with a clear enable keep their stored byte.
      for (int b = 0; b < WIDTH / 8; b++) begin
        if (we_i[b]) begin
          mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
        end
      end
    end
  end

  // a read with en_i low leaves dat_o unchanged.
  // a write with all we_i bits low is a plain read.
  // DEPTH is expected to be a power of two, since the address port is
  // sized by $clog2 and a larger index would fall outside the array.
  // WIDTH must be a multiple of 8 for the byte lanes to cover the word.

endmodule

/* design/wb_bank_decoder.sv */
// Purely combinational; lane bits are left to sel, and any address bit at 12 or above is a miss.
`timescale 1ns/1ps

module wb_bank_decoder (
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic [wb_mem_pkg::ADR_W-1:0]     wb_adr_i,
  output logic [wb_mem_pkg::NUM_BANKS-1:0] bank_stb_o,
  output logic [wb_mem_pkg::WORD_W-1:0]    word_adr_o,
  output logic                             req_miss_o
);

  // a live request needs both cyc and stb.
  logic                           req;

  // high when no address bit above the mapped region is set.
  logic                           mapped;

  // bank number taken from the bits just above the word field.
  logic [wb_mem_pkg::BANK_W-1:0]  bank_idx;

  assign req = wb_cyc_i & wb_stb_i;

  // the upper address bits must all be zero for a hit.
  assign mapped = ~|wb_adr_i[wb_mem_pkg::ADR_W-1:wb_mem_pkg::MAP_TOP];

  // the word index skips the byte-lane bits.
  // it goes to every bank, and only the strobed bank uses it.
  assign word_adr_o = wb_adr_i[wb_mem_pkg::LANE_W +: wb_mem_pkg::WORD_W];

  assign bank_idx =
    wb_adr_i[wb_mem_pkg::LANE_W + wb_mem_pkg::WORD_W +: wb_mem_pkg::BANK_W];

  // one-hot strobe for the addressed bank and a miss flag otherwise.
  // the bank count equals 2**BANK_W, so every index has a bank.
  // an idle bus keeps all strobes low and raises no miss.
  always_comb begin
    bank_stb_o = '0;
    req_miss_o = 1'b0;
    if (req) begin
      if (mapped) begin
        bank_stb_o[bank_idx] = 1'b1;
      end else begin
        // unmapped requests never reach a bank.
        // the collector answers them with err.
        req_miss_o = 1'b1;
      end
    end
  end

  // sel, we and the write data do not depend on the address.
  // they go from the top level to all banks unchanged.
  // mapped addresses on an idle bus are ignored by design.

endmodule

/* design/wb_mem_pkg.sv */
// Map constants are fixed at 4 banks of 256 words of 32 bits, and changing them re-sizes every module.
package wb_mem_pkg;

  // width of the wishbone byte address seen at the slave port.
  localparam int unsigned ADR_W = 32;

  // width of the wishbone data bus in both directions.
  localparam int unsigned DAT_W = 32;

  // one select bit per byte lane of the data bus.
  localparam int unsigned SEL_W = DAT_W / 8;

  // the low address bits pick a byte inside a word.
  // sel already carries the lane information, so these bits only
  // offset the word field and are not decoded.
  localparam int unsigned LANE_W = 2;

  // word index inside one bank, giving 256 words per bank.
  localparam int unsigned WORD_W = 8;

  // bank index, which sits directly above the word field.
  localparam int unsigned BANK_W = 2;

  // every value of the bank index maps to a generated bank,
  // so the decoder never sees an out-of-range bank number.
  localparam int unsigned NUM_BANKS = 1 << BANK_W;

  // first address bit above the mapped region.
  // any set bit from here up to ADR_W-1 is a decode miss and gets err.
  localparam int unsigned MAP_TOP = LANE_W + WORD_W + BANK_W;

  // resulting map:
  //   [1:0]   byte lane
  //   [9:2]   word
  //   [11:10] bank
  //   [31:12] must be zero
  // so the mapped region is 4 KiB starting at address zero.

endpackage

/* design/wb_ram.sv */
// Classic cycles only, one access per strobe with a fixed one-cycle ack; cyc is qualified upstream.
`timescale 1ns/1ps

module wb_ram (
  input  logic                           wb_clk_i,
  input  logic                           wb_rst_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [wb_mem_pkg::SEL_W-1:0]   wb_sel_i,
  input  logic [wb_mem_pkg::WORD_W-1:0]  wb_adr_i,
  input  logic [wb_mem_pkg::DAT_W-1:0]   wb_dat_i,
  output logic [wb_mem_pkg::DAT_W-1:0]   wb_dat_o,
  output logic                           wb_ack_o
);

  // registered acknowledge for the access of the previous cycle.
  logic                          ack_q;

  // gated memory controls.
  logic                          mem_en;
  logic [wb_mem_pkg::SEL_W-1:0]  mem_we;

  // an access starts when the strobe is high and no ack is out.
  // the master still holds its request during the ack cycle, so
  // blocking that cycle stops a held strobe from being taken twice.
  assign mem_en = wb_stb_i & ~ack_q;

  // byte write enables follow sel only on an accepted write.
  // a read leaves every lane enable low.
  assign mem_we = wb_sel_i & {wb_mem_pkg::SEL_W{wb_we_i & mem_en}};

  // the word index comes straight from the decoder.
  // the read data register inside the macro loads at the same edge as
  // ack_q, so read data and ack are valid in the same cycle.
  sram_sp_be #(
    .WIDTH (wb_mem_pkg::DAT_W),
    .DEPTH (1 << wb_mem_pkg::WORD_W)
  ) sram_inst (
    .clk_i (wb_clk_i),
    .en_i  (mem_en),
    .we_i  (mem_we),
    .adr_i (wb_adr_i),
    .dat_i (wb_dat_i),
    .dat_o (wb_dat_o)
  );

  // ack rises one cycle after an accepted access and falls the next.
  // it is the only control state of the bank.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= mem_en;
    end
  end

  assign wb_ack_o = ack_q;

  // a held strobe must never turn into back-to-back acks.
  // the collector counts on single-cycle acks for its data mux.
  a_ack_single : assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o
  ) else $error("wb_ram: ack held high for two cycles");

endmodule

/* design/wb_ram_bank.sv */
// Wishbone B3 classic slave, one request in flight, no bursts or wait states; unmapped addresses get err.
`timescale 1ns/1ps

module wb_ram_bank (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [wb_mem_pkg::ADR_W-1:0]  wb_adr_i,
  input  logic [wb_mem_pkg::SEL_W-1:0]  wb_sel_i,
  input  logic [wb_mem_pkg::DAT_W-1:0]  wb_dat_i,
  output logic [wb_mem_pkg::DAT_W-1:0]  wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          wb_err_o
);

  // decoder outputs.
  logic [wb_mem_pkg::NUM_BANKS-1:0]                   bank_stb;
  logic [wb_mem_pkg::WORD_W-1:0]                      word_adr;
  logic                                               req_miss;

  // bank responses, with bank i in slice i of the data vector.
  logic [wb_mem_pkg::NUM_BANKS-1:0]                   bank_ack;
  logic [wb_mem_pkg::NUM_BANKS*wb_mem_pkg::DAT_W-1:0] bank_dat;

  // the decoder qualifies the strobe with cyc and the address map.
  wb_bank_decoder decoder_inst (
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_adr_i   (wb_adr_i),
    .bank_stb_o (bank_stb),
    .word_adr_o (word_adr),
    .req_miss_o (req_miss)
  );

  // identical banks share the word index, sel, we and write data.
  // only the bank with its strobe high takes the access.
  for (genvar i = 0; i < wb_mem_pkg::NUM_BANKS; i++) begin : g_bank
    wb_ram bank_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_stb_i (bank_stb[i]),
      .wb_we_i  (wb_we_i),
      .wb_sel_i (wb_sel_i),
      .wb_adr_i (word_adr),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (bank_dat[i*wb_mem_pkg::DAT_W +: wb_mem_pkg::DAT_W]),
      .wb_ack_o (bank_ack[i])
    );
  end

  // the collector builds the single slave response.
  wb_resp_collect collect_inst (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .bank_ack_i (bank_ack),
    .bank_dat_i (bank_dat),
    .req_miss_i (req_miss),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o)
  );

endmodule

/* design/wb_resp_collect.sv */
// Assumes at most one bank acks per cycle; read data is only meaningful while wb_ack_o is high.
`timescale 1ns/1ps

module wb_resp_collect (
  input  logic                                             wb_clk_i,
  input  logic                                             wb_rst_i,
  input  logic [wb_mem_pkg::NUM_BANKS-1:0]                 bank_ack_i,
  input  logic [wb_mem_pkg::NUM_BANKS*wb_mem_pkg::DAT_W-1:0] bank_dat_i,
  input  logic                                             req_miss_i,
  output logic [wb_mem_pkg::DAT_W-1:0]                     wb_dat_o,
  output logic                                             wb_ack_o,
  output logic                                             wb_err_o
);

  // registered error for a decode miss sampled in the previous cycle.
  logic err_q;

  // any bank ack is the slave ack.
  assign wb_ack_o = |bank_ack_i;

  // and-or mux of the bank read data.
  // each bank holds its last read word while idle, so its data is
  // masked by its own ack and only the answering bank gets through.
  always_comb begin
    wb_dat_o = '0;
    for (int i = 0; i < wb_mem_pkg::NUM_BANKS; i++) begin
      wb_dat_o = wb_dat_o | (bank_dat_i[i*wb_mem_pkg::DAT_W +: wb_mem_pkg::DAT_W]
                             & {wb_mem_pkg::DAT_W{bank_ack_i[i]}});
    end
  end

  // err follows the same rules as a bank ack.
  // it rises one cycle after the miss is sampled and is not repeated
  // while the master keeps the same miss request on the bus.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_miss_i & ~err_q;
    end
  end

  assign wb_err_o = err_q;

  // only one bank can hold a request, so only one bank may answer.
  a_one_bank_ack : assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(bank_ack_i)
  ) else $error("wb_resp_collect: several banks acked in one cycle");

  // each request gets exactly one kind of response.
  a_ack_err_excl : assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o)
  ) else $error("wb_resp_collect: ack and err high together");

endmodule

/* dv/wb_ram_bank_patterns.hex */
// columns: op flags address sel write_data expected_read_data, one access per line
// op 0 idle, 1 write, 2 read, ff end; flags bit0 err expected, bit1 idle cycle after response
00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000000 00000014 0000000f 11111111 00000000
00000001 00000000 00000414 0000000f 22222222 00000000
00000001 00000000 00000814 0000000f 33333333 00000000
00000001 00000002 00000c14 0000000f 44444444 00000000
00000002 00000000 00000014 0000000f 00000000 11111111
00000002 00000000 00000414 0000000f 00000000 22222222
00000002 00000000 00000814 0000000f 00000000 33333333
00000002 00000002 00000c14 0000000f 00000000 44444444
00000001 00000000 00000100 0000000f a5a5a5a5 00000000
00000001 00000000 00000100 00000001 000000c3 00000000
00000001 00000000 00000100 00000004 00de0000 00000000
00000002 00000000 00000100 0000000f 00000000 a5dea5c3
00000001 00000000 00000900 0000000f 01234567 00000000
00000001 00000000 00000900 0000000a 89abcdef 00000000
00000002 00000002 00000900 0000000f 00000000 8923cd67
00000001 00000001 00001014 0000000f deadbeef 00000000
00000002 00000001 80000414 0000000f 00000000 00000000
00000001 00000003 00f00814 00000003 cafef00d 00000000
00000002 00000000 00000014 0000000f 00000000 11111111
00000002 00000000 00000414 0000000f 00000000 22222222
00000002 00000002 00000814 0000000f 00000000 33333333
00000001 00000002 00000c20 0000000f 55aa55aa 00000000
00000001 00000000 00000c20 0000000f 0f0f0f0f 00000000
00000001 00000000 00000c20 00000002 0000bb00 00000000
00000002 00000002 00000c20 0000000f 00000000 0f0fbb0f
00000000 00000000 00000000 00000000 00000000 00000000
000000ff 00000000 00000000 00000000 00000000 00000000

/* dv/wb_ram_bank_tb.sv */
// Reads dv/wb_ram_bank_patterns.hex relative to the run directory; expects one-cycle responses.
`timescale 1ns/1ps

module wb_ram_bank_tb;

  // each access takes six words of the pattern file, one per column.
  localparam int COLS    = 6;
  localparam int MAX_PAT = 64;

  localparam logic [31:0] OP_IDLE  = 32'h0;
  localparam logic [31:0] OP_WRITE = 32'h1;
  localparam logic [31:0] OP_READ  = 32'h2;
  localparam logic [31:0] OP_END   = 32'hff;

  logic                           wb_clk_i;
  logic                           wb_rst_i;
  logic                           wb_cyc_i;
  logic                           wb_stb_i;
  logic                           wb_we_i;
  logic [wb_mem_pkg::ADR_W-1:0]   wb_adr_i;
  logic [wb_mem_pkg::SEL_W-1:0]   wb_sel_i;
  logic [wb_mem_pkg::DAT_W-1:0]   wb_dat_i;
  logic [wb_mem_pkg::DAT_W-1:0]   wb_dat_o;
  logic                           wb_ack_o;
  logic                           wb_err_o;

  // raw pattern table and a lane-wise model of the mapped 4 KiB.
  logic [31:0] pat_mem [0:COLS*MAX_PAT-1];
  logic [31:0] shadow [0:1023];
  logic [3:0]  shadow_vld [0:1023];

  int num_pat;
  int pass_count;
  int fail_count;
  int cycle_count = 0;
  int cycle_limit = 1000000;
  bit pat_failed;

  wb_ram_bank wb_ram_bank_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #50 wb_clk_i = ~wb_clk_i;
  end

  // the limit is set once the pattern count is known.
  always @(posedge wb_clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped after %0d cycles, the DUT stopped answering", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic string op_name(input logic [31:0] op);
    case (op)
      OP_IDLE:  return "idle";
      OP_WRITE: return "write";
      OP_READ:  return "read";
      default:  return "unknown";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s: expected %h actual %h", name, what, exp, act);
    pat_failed = 1'b1;
  endtask

  task automatic drive_idle();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
  endtask

  task automatic finish_pattern(input string name);
    if (pat_failed) begin
      fail_count++;
      $display("%s: failed", name);
    end else begin
      pass_count++;
      $display("%s: ok", name);
    end
  endtask

  // only the selected lanes of a mapped write reach memory.
  task automatic update_model(input logic [31:0] addr, input logic [31:0] sel,
                              input logic [31:0] wdata);
    logic [9:0] widx;
    widx = addr[wb_mem_pkg::MAP_TOP-1:wb_mem_pkg::LANE_W];
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        shadow[widx][b*8 +: 8] = wdata[b*8 +: 8];
        shadow_vld[widx][b] = 1'b1;
      end
    end
  endtask

  // bus left idle for three cycles must stay silent.
  task automatic check_idle(input int idx);
    string name;
    name = $sformatf("pattern %0d idle", idx);
    pat_failed = 1'b0;
    @(posedge wb_clk_i);
    #1;
    drive_idle();
    repeat (3) begin
      @(negedge wb_clk_i);
      if (wb_ack_o !== 1'b0) begin
        report_mismatch(name, "ack on idle bus", 32'h0, 32'(wb_ack_o));
      end
      if (wb_err_o !== 1'b0) begin
        report_mismatch(name, "err on idle bus", 32'h0, 32'(wb_err_o));
      end
    end
    finish_pattern(name);
  endtask

  // one classic cycle. flags bit 0 means err is expected, bit 1 puts an
  // idle cycle after the response in which a duplicate would show.
  task automatic run_access(input int idx);
    logic [31:0] op;
    logic [31:0] flags;
    logic [31:0] addr;
    logic [31:0] sel;
    logic [31:0] wdata;
    logic [31:0] expd;
    logic [9:0]  widx;
    logic        mapped;
    string       name;
    int          waited;
    op     = pat_mem[idx*COLS];
    flags  = pat_mem[idx*COLS+1];
    addr   = pat_mem[idx*COLS+2];
    sel    = pat_mem[idx*COLS+3];
    wdata  = pat_mem[idx*COLS+4];
    expd   = pat_mem[idx*COLS+5];
    widx   = addr[wb_mem_pkg::MAP_TOP-1:wb_mem_pkg::LANE_W];
    mapped = ((addr >> wb_mem_pkg::MAP_TOP) == 32'h0);
    name   = $sformatf("pattern %0d %s %h", idx, op_name(op), addr);
    pat_failed = 1'b0;
    @(posedge wb_clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = (op == OP_WRITE);
    wb_adr_i = addr;
    wb_sel_i = sel[3:0];
    wb_dat_i = wdata;
    // the DUT samples at the next edge, so the answer is due at the second falling edge.
    for (waited = 1; waited <= 4; waited++) begin
      @(negedge wb_clk_i);
      if (wb_ack_o === 1'b1 || wb_err_o === 1'b1) begin
        break;
      end
    end
    if (waited > 4) begin
      $display("%s: the access got no ack or err within four cycles", name);
      pat_failed = 1'b1;
    end else begin
      if (waited != 2) begin
        report_mismatch(name, "response cycle", 32'd2, 32'(waited));
      end
      if (wb_err_o !== flags[0]) begin
        report_mismatch(name, "err", 32'(flags[0]), 32'(wb_err_o));
      end
      if (wb_ack_o !== !flags[0]) begin
        report_mismatch(name, "ack", 32'(!flags[0]), 32'(wb_ack_o));
      end
      if (op == OP_READ && !flags[0]) begin
        if (wb_dat_o !== expd) begin
          report_mismatch(name, "read data", expd, wb_dat_o);
        end
        if (shadow_vld[widx] == 4'hf && wb_dat_o !== shadow[widx]) begin
          report_mismatch(name, "data against model", shadow[widx], wb_dat_o);
        end
      end
    end
    if (op == OP_WRITE && mapped) begin
      update_model(addr, sel, wdata);
    end
    if (flags[1]) begin
      @(posedge wb_clk_i);
      #1;
      drive_idle();
      @(negedge wb_clk_i);
      if (wb_ack_o !== 1'b0) begin
        report_mismatch(name, "duplicate ack", 32'h0, 32'(wb_ack_o));
      end
      if (wb_err_o !== 1'b0) begin
        report_mismatch(name, "duplicate err", 32'h0, 32'(wb_err_o));
      end
    end
    finish_pattern(name);
  endtask

  initial begin
    int i;
    wb_rst_i = 1'b1;
    drive_idle();
    pass_count = 0;
    fail_count = 0;
    for (i = 0; i < 1024; i++) begin
      shadow_vld[i] = 4'h0;
    end
    $readmemh("dv/wb_ram_bank_patterns.hex", pat_mem);
    num_pat = 0;
    while (num_pat < MAX_PAT && pat_mem[num_pat*COLS] != OP_END) begin
      num_pat++;
    end
    // at most four cycles per pattern, plus reset and some slack.
    cycle_limit = num_pat * 4 + 10 + 20;
    if (num_pat == 0) begin
      $display("no patterns were read from the pattern file");
      fail_count++;
    end
    repeat (10) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    for (i = 0; i < num_pat; i++) begin
      case (pat_mem[i*COLS])
        OP_IDLE:  check_idle(i);
        OP_WRITE: run_access(i);
        OP_READ:  run_access(i);
        default: begin
          $display("pattern %0d has an unknown operation code", i);
          fail_count++;
        end
      endcase
    end
    @(posedge wb_clk_i);
    #1;
    drive_idle();
    $display("patterns passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* wb_ram_bank.f */
design/wb_mem_pkg.sv
design/sram_sp_be.sv
design/wb_ram.sv
design/wb_bank_decoder.sv
design/wb_resp_collect.sv
design/wb_ram_bank.sv
dv/wb_ram_bank_tb.sv
